// ==== list.f ====
+incdir+source
source/csr_pkg.sv
source/csr_decode.sv
source/machine_csrs.sv
source/perf_counters.sv
source/trap_ctrl.sv
source/csr_unit.sv
verif/csr_checker.sv
verif/tb_csr_unit.sv

// ==== Makefile ====
# Verilator build and run of the CSR unit testbench

VERILATOR ?= verilator
TOP       ?= tb_csr_unit
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the verdict"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== verif/tb_csr_unit.sv ====
// CSR unit testbench
// clock and reset, directed phases and LFSR driven stimulus
// on the falling edge, run timeout and the final verdict

`timescale 1ns/100ps

`include "csr_defines.svh"

module tb_csr_unit;

  import csr_pkg::*;

  localparam int n_cnt           = `N_PERF_CNT;
  localparam int n_ext           = `N_EXT_CNT;
  localparam int reset_cycles    = 16;
  localparam int machine_cycles  = 200;   // machine CSR ops only
  localparam int rand_cycles     = 3000;  // everything mixed
  localparam int directed_cycles = 120;   // reset reads, traps, counters
  localparam int max_cycles      = reset_cycles + machine_cycles + rand_cycles
                                   + directed_cycles + 100;

  logic               clk = 1'b0;
  logic               rst_n;
  csr_req_t           csr_req_i;
  logic [9:0]         hart_id_i;
  logic               exc_req_i;
  csr_data_t          exc_pc_i;
  exc_cause_t         exc_cause_i;
  logic               irq_i;
  logic [4:0]         irq_id_i;
  csr_data_t          irq_pc_i;
  logic               mret_i;
  perf_evt_t          perf_evt_i;
  logic [n_ext-1:0]   ext_evt_i;
  csr_data_t          csr_rdata_o;
  logic               irq_enable_o;
  csr_data_t          mepc_o;
  logic               trap_o;
  logic               in_handler_o;

  int          n_checks, n_errors;
  int          cycle_cnt = 0;
  logic [31:0] lfsr = 32'hcc3;

  always #4 clk = ~clk;   // 8 ns

  csr_unit i_csr_unit (.*);

  csr_checker i_csr_checker (
    .*,
    .csr_rdata_i  (csr_rdata_o),
    .irq_enable_i (irq_enable_o),
    .mepc_i       (mepc_o),
    .trap_i       (trap_o),
    .in_handler_i (in_handler_o),
    .n_checks_o   (n_checks),
    .n_errors_o   (n_errors)
  );

  always @(posedge clk)
  begin
    cycle_cnt++;
    if (cycle_cnt >= max_cycles)
    begin
      $display("timeout: run did not finish within %0d cycles", max_cycles);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  //////////////////////////////
  // stimulus helpers
  //////////////////////////////

  // Galois LFSR, one shift per bit handed out
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int k = 0; k < n; k++)
    begin
      r    = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hd000_0001) : (lfsr >> 1);
    end
    return r;
  endfunction

  function automatic csr_addr_t pick_addr(input logic [3:0] p, input logic [3:0] idx);
    case (p)
      4'd0:    return `CSR_MSTATUS;
      4'd1:    return `CSR_MEPC;
      4'd2:    return `CSR_MCAUSE;
      4'd3:    return `CSR_MISA;
      4'd4:    return `CSR_MIMPID;
      4'd5:    return `CSR_MHARTID;
      4'd6:    return `CSR_PCER;
      4'd7:    return `CSR_PCMR;
      4'd8:    return 12'h7ff;            // unmapped
      4'd9:    return `CSR_PCCR_ALL;
      default: return `CSR_PCCR_BASE + {8'h0, idx};  // 78D..78F unmapped
    endcase
  endfunction

  task automatic csr_access(input csr_op_e kind, input csr_addr_t addr, input csr_data_t wd);
    @(negedge clk);
    csr_req_i = '{1'b1, kind, addr, wd};
  endtask

  task automatic idle(input int n);
    repeat (n)
    begin
      @(negedge clk);
      csr_req_i.access = 1'b0;
    end
  endtask

  // full adds counter addresses, events and traps
  task automatic random_cycle(input logic full);
    logic [31:0] r;
    logic [3:0]  pick;
    @(negedge clk);
    r = take_bits(3);
    csr_req_i.access = r[2];
    csr_req_i.op     = csr_op_e'(r[1:0]);
    csr_req_i.wdata  = take_bits(32);
    r    = take_bits(8);
    pick = full ? r[3:0] : (r[3:0] % 4'd6);
    csr_req_i.addr = pick_addr(pick, r[7:4]);
    if (full)
    begin
      r = take_bits(10 + n_ext);
      perf_evt_i  = perf_evt_t'(r[9:0]);
      ext_evt_i   = r[10 +: n_ext];
      r = take_bits(6);
      exc_req_i   = (r[3:0] == 4'd0);   // about one in 16
      irq_i       = (r[5:4] == 2'd0);
      exc_pc_i    = take_bits(32);
      exc_cause_i = 6'(take_bits(6));
      irq_pc_i    = take_bits(32);
      irq_id_i    = 5'(take_bits(5));
      r = take_bits(2);
      mret_i      = in_handler_o && (r[1:0] == 2'd0);
      if (mret_i)
      begin
        exc_req_i = 1'b0;   // keep traps off the mret cycle
        irq_i     = 1'b0;
      end
    end
  endtask

  //////////////////////////////
  // test sequence
  //////////////////////////////

  initial
  begin
    rst_n       = 1'b0;
    csr_req_i   = '0;
    hart_id_i   = 10'h2a5;
    exc_req_i   = 1'b0;
    exc_pc_i    = '0;
    exc_cause_i = '0;
    irq_i       = 1'b0;
    irq_id_i    = '0;
    irq_pc_i    = '0;
    mret_i      = 1'b0;
    perf_evt_i  = '0;
    ext_evt_i   = '0;
    repeat (reset_cycles) @(negedge clk);
    rst_n = 1'b1;

    // reset values, counter reads go through set with zero
    csr_access(CSR_OP_SET, `CSR_PCMR, '0);
    csr_access(CSR_OP_SET, `CSR_PCER, '0);
    for (int i = 0; i < n_cnt; i++)
      csr_access(CSR_OP_SET, `CSR_PCCR_BASE + 12'(i), '0);
    csr_access(CSR_OP_NONE, `CSR_MSTATUS, '0);
    idle(2);

    repeat (machine_cycles) random_cycle(1'b0);
    idle(2);

    // exception and interrupt together with MIE set
    csr_access(CSR_OP_WRITE, `CSR_MSTATUS, 32'h0000_0008);
    idle(1);
    exc_req_i   = 1'b1;
    exc_pc_i    = 32'h0000_1234;
    exc_cause_i = 6'h0b;
    irq_i       = 1'b1;
    irq_id_i    = 5'd11;
    irq_pc_i    = 32'h0000_4320;
    idle(1);
    exc_req_i = 1'b0;                         // irq held, MIE now low
    csr_access(CSR_OP_NONE, `CSR_MCAUSE, '0);
    csr_access(CSR_OP_NONE, `CSR_MSTATUS, '0);
    idle(1);
    irq_i  = 1'b0;
    mret_i = 1'b1;
    idle(1);
    mret_i = 1'b0;
    irq_i  = 1'b1;                            // MIE back, irq traps
    idle(1);
    irq_i = 1'b0;
    csr_access(CSR_OP_NONE, `CSR_MCAUSE, '0);
    idle(1);
    mret_i = 1'b1;
    idle(1);
    mret_i = 1'b0;
    csr_access(CSR_OP_CLEAR, `CSR_MSTATUS, 32'h0000_0008);

    // counting, then frozen with PCMR enable off
    csr_access(CSR_OP_WRITE, `CSR_PCER, '1);
    idle(1);
    perf_evt_i = '1;
    ext_evt_i  = '1;
    idle(10);
    csr_access(CSR_OP_SET, `CSR_PCCR_BASE + 12'd1, '0);
    csr_access(CSR_OP_WRITE, `CSR_PCMR, 32'h0000_0002);
    idle(6);
    csr_access(CSR_OP_SET, `CSR_PCCR_BASE, '0);

    // saturate, then wrap, preload collides with increments
    csr_access(CSR_OP_WRITE, `CSR_PCMR, 32'h0000_0003);
    csr_access(CSR_OP_WRITE, `CSR_PCCR_BASE + 12'd1, 32'hffff_fffc);
    idle(8);
    csr_access(CSR_OP_SET, `CSR_PCCR_BASE + 12'd1, '0);
    csr_access(CSR_OP_WRITE, `CSR_PCMR, 32'h0000_0001);
    csr_access(CSR_OP_WRITE, `CSR_PCCR_BASE + 12'd2, 32'hffff_fffe);
    idle(6);
    csr_access(CSR_OP_SET, `CSR_PCCR_BASE + 12'd2, '0);

    // all counters at once
    csr_access(CSR_OP_WRITE, `CSR_PCCR_ALL, 32'h0000_0100);
    idle(3);
    for (int i = 0; i < n_cnt; i++)
      csr_access(CSR_OP_SET, `CSR_PCCR_BASE + 12'(i), '0);
    perf_evt_i = '0;
    ext_evt_i  = '0;

    repeat (rand_cycles) random_cycle(1'b1);
    exc_req_i = 1'b0;
    irq_i     = 1'b0;
    mret_i    = 1'b0;
    idle(4);

    $display("checks %0d, errors %0d", n_checks, n_errors);
    if ((n_errors == 0) && (n_checks > 0))
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// ==== verif/csr_checker.sv ====
// CSR unit checker
// reference model of the machine CSRs, trap sequencing and the
// counter bank, stepped on every rising edge and compared
// against the DUT ports, counts checks and mismatches

`timescale 1ns/100ps

`include "csr_defines.svh"

module csr_checker (
  input  logic                  clk,
  input  logic                  rst_n,
  input  csr_pkg::csr_req_t     csr_req_i,
  input  logic [9:0]            hart_id_i,
  input  logic                  exc_req_i,
  input  csr_pkg::csr_data_t    exc_pc_i,
  input  csr_pkg::exc_cause_t   exc_cause_i,
  input  logic                  irq_i,
  input  logic [4:0]            irq_id_i,
  input  csr_pkg::csr_data_t    irq_pc_i,
  input  logic                  mret_i,
  input  csr_pkg::perf_evt_t    perf_evt_i,
  input  logic [`N_EXT_CNT-1:0] ext_evt_i,
  input  csr_pkg::csr_data_t    csr_rdata_i,   // DUT outputs
  input  logic                  irq_enable_i,
  input  csr_pkg::csr_data_t    mepc_i,
  input  logic                  trap_i,
  input  logic                  in_handler_i,
  output int                    n_checks_o,
  output int                    n_errors_o
);

  import csr_pkg::*;

  localparam int n_cnt = `N_PERF_CNT;

  int n_checks = 0;
  int n_errors = 0;

  // model state
  logic             m_mie, m_mpie, m_handler;
  csr_data_t        m_mepc;
  exc_cause_t       m_mcause;
  logic [1:0]       m_pcmr;             // [1] saturate, [0] enable
  logic [n_cnt-1:0] m_pcer;
  logic [n_cnt-1:0] m_pend;             // events waiting for the add
  csr_data_t        m_cnt [n_cnt];

  // per edge scratch
  csr_data_t        rd, wval;
  logic             wr, take, mie_old, mpie_old;
  logic [n_cnt-1:0] nxt_pend;
  int               idx;

  assign n_checks_o = n_checks;
  assign n_errors_o = n_errors;

  //////////////////////////////
  // reference functions
  //////////////////////////////

  // PCER, PCMR and the whole 780..79F window
  function automatic logic is_perf_addr(input csr_addr_t a);
    return (a == `CSR_PCER) || (a == `CSR_PCMR) || (a[11:5] == 7'h3c);
  endfunction

  function automatic csr_data_t read_value(input csr_req_t r);
    csr_data_t v;
    int        i;
    v = '0;
    i = int'(r.addr[4:0]);
    if (r.access)
    begin
      case (r.addr)
        `CSR_MSTATUS:
        begin
          v[7] = m_mpie;
          v[3] = m_mie;
        end
        `CSR_MEPC:    v = m_mepc;
        `CSR_MCAUSE:
        begin
          v[31]  = m_mcause[5];        // interrupt flag
          v[4:0] = m_mcause[4:0];
        end
        `CSR_MHARTID: v[9:0] = hart_id_i;
        `CSR_PCER:    v[n_cnt-1:0] = m_pcer;
        `CSR_PCMR:    v[1:0] = m_pcmr;
        default:
        begin
          if ((r.addr[11:5] == 7'h3c) && (i < n_cnt))
            v = m_cnt[i];
        end
      endcase
      // counter bank answers only to a real op
      if ((r.op == CSR_OP_NONE) && is_perf_addr(r.addr))
        v = '0;
    end
    return v;
  endfunction

  function automatic csr_data_t combine_op(input csr_op_e op, input csr_data_t wd,
                                           input csr_data_t cur);
    csr_data_t v;
    case (op)
      CSR_OP_SET:   v = cur | wd;
      CSR_OP_CLEAR: v = cur & ~wd;
      default:      v = wd;
    endcase
    return v;
  endfunction

  // raw event per counter, cycles first
  function automatic logic [n_cnt-1:0] event_vector();
    logic [n_cnt-1:0] e;
    e[0] = 1'b1;
    for (int k = 1; k < `N_INT_CNT; k++)
      e[k] = perf_evt_i[`N_INT_CNT - 1 - k];   // instr is the struct msb
    for (int k = 0; k < `N_EXT_CNT; k++)
      e[`N_INT_CNT + k] = ext_evt_i[k];
    return e;
  endfunction

  function automatic logic trap_taken();
    return exc_req_i || (irq_i && m_mie);   // exception needs no enable
  endfunction

  task automatic compare(input string name, input csr_data_t got, input csr_data_t exp);
    n_checks++;
    if (got !== exp)
    begin
      n_errors++;
      $display("CHECK FAILED %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  //////////////////////////////
  // compare, then step model
  //////////////////////////////

  always @(posedge clk)
  begin
    if (!rst_n)
    begin
      m_mie     = 1'b0;
      m_mpie    = 1'b0;
      m_handler = 1'b0;
      m_mepc    = '0;
      m_mcause  = '0;
      m_pcmr    = `PCMR_RST;
      m_pcer    = '0;
      m_pend    = '0;
      for (int i = 0; i < n_cnt; i++)
        m_cnt[i] = '0;
    end
    else
    begin
      rd       = read_value(csr_req_i);
      wval     = combine_op(csr_req_i.op, csr_req_i.wdata, rd);
      wr       = csr_req_i.access && (csr_req_i.op != CSR_OP_NONE);
      take     = trap_taken();
      mie_old  = m_mie;
      mpie_old = m_mpie;
      idx      = int'(csr_req_i.addr[4:0]);

      compare("csr_rdata_o", csr_rdata_i, rd);
      compare("trap_o", 32'(trap_i), 32'(take));
      compare("irq_enable_o", 32'(irq_enable_i), 32'(m_mie));
      compare("mepc_o", mepc_i, m_mepc);
      compare("in_handler_o", 32'(in_handler_i), 32'(m_handler));

      // gated with the old enables, added one edge later
      nxt_pend = event_vector() & m_pcer & {n_cnt{m_pcmr[0]}};
      for (int i = 0; i < n_cnt; i++)
      begin
        if (m_pend[i] && !(m_pcmr[1] && (m_cnt[i] == '1)))
          m_cnt[i] = m_cnt[i] + 32'd1;   // wraps without saturate
      end

      if (wr)
      begin
        case (csr_req_i.addr)
          `CSR_MSTATUS:
          begin
            m_mie  = wval[3];
            m_mpie = wval[7];
          end
          `CSR_MEPC:     m_mepc = wval;
          `CSR_MCAUSE:   m_mcause = {wval[31], wval[4:0]};
          `CSR_PCER:     m_pcer = wval[n_cnt-1:0];
          `CSR_PCMR:     m_pcmr = wval[1:0];
          `CSR_PCCR_ALL:
          begin
            for (int i = 0; i < n_cnt; i++)
              m_cnt[i] = wval;
          end
          default:
          begin
            if ((csr_req_i.addr[11:5] == 7'h3c) && (idx < n_cnt))
              m_cnt[idx] = wval;    // write beats the add
          end
        endcase
      end
      m_pend = nxt_pend;

      // trap entry over mret, both over software writes
      if (take)
      begin
        m_mepc    = exc_req_i ? exc_pc_i : irq_pc_i;
        m_mcause  = exc_req_i ? exc_cause_i : {1'b1, irq_id_i};
        m_mpie    = mie_old;
        m_mie     = 1'b0;
        m_handler = 1'b1;
      end
      else if (mret_i && m_handler)
      begin
        m_mie     = mpie_old;
        m_handler = 1'b0;
      end
    end
  end

endmodule

// ==== source/csr_unit.sv ====
// machine mode CSR unit top
// CSR request port, machine CSRs, trap sequencing and
// the performance counter bank of a small RV32 core

`timescale 1ns/100ps

`include "csr_defines.svh"

module csr_unit (
  input  logic                  clk,
  input  logic                  rst_n,
  // CSR port
  input  csr_pkg::csr_req_t     csr_req_i,
  output csr_pkg::csr_data_t    csr_rdata_o,
  input  logic [9:0]            hart_id_i,
  // traps
  input  logic                  exc_req_i,
  input  csr_pkg::csr_data_t    exc_pc_i,
  input  csr_pkg::exc_cause_t   exc_cause_i,
  input  logic                  irq_i,
  input  logic [4:0]            irq_id_i,
  input  csr_pkg::csr_data_t    irq_pc_i,
  input  logic                  mret_i,
  output logic                  irq_enable_o,
  output csr_pkg::csr_data_t    mepc_o,
  output logic                  trap_o,
  output logic                  in_handler_o,
  // counter events
  input  csr_pkg::perf_evt_t    perf_evt_i,
  input  logic [`N_EXT_CNT-1:0] ext_evt_i
);

  import csr_pkg::*;

  csr_sel_t   sel;
  csr_data_t  wdata_int;    // op combined write value
  csr_data_t  mach_rdata;
  csr_data_t  perf_rdata;
  trap_save_t save;
  logic       restore;
  logic       mie;

  csr_decode i_csr_decode (
    .clk          (clk),
    .rst_n        (rst_n),
    .csr_req_i    (csr_req_i),
    .mach_rdata_i (mach_rdata),
    .perf_rdata_i (perf_rdata),
    .sel_o        (sel),
    .wdata_o      (wdata_int),
    .csr_rdata_o  (csr_rdata_o)
  );

  machine_csrs i_machine_csrs (
    .clk         (clk),
    .rst_n       (rst_n),
    .sel_i       (sel),
    .wdata_i     (wdata_int),
    .hart_id_i   (hart_id_i),
    .read_addr_i (csr_req_i.addr),
    .save_i      (save),
    .restore_i   (restore),
    .rdata_o     (mach_rdata),
    .mie_o       (mie),
    .mepc_o      (mepc_o)
  );

  perf_counters i_perf_counters (
    .clk        (clk),
    .rst_n      (rst_n),
    .sel_i      (sel),
    .wdata_i    (wdata_int),
    .perf_evt_i (perf_evt_i),
    .ext_evt_i  (ext_evt_i),
    .rdata_o    (perf_rdata)
  );

  trap_ctrl i_trap_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .exc_req_i    (exc_req_i),
    .exc_pc_i     (exc_pc_i),
    .exc_cause_i  (exc_cause_i),
    .irq_i        (irq_i),
    .irq_id_i     (irq_id_i),
    .irq_pc_i     (irq_pc_i),
    .mie_i        (mie),
    .mret_i       (mret_i),
    .save_o       (save),
    .restore_o    (restore),
    .trap_o       (trap_o),
    .in_handler_o (in_handler_o)
  );

  assign irq_enable_o = mie;

endmodule

// ==== source/trap_ctrl.sv ====
// trap controller
// exception over interrupt arbitration, save strobe on entry,
// restore strobe on mret, tracks run / handler state

`timescale 1ns/100ps

module trap_ctrl (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 exc_req_i,    // pulse
  input  csr_pkg::csr_data_t   exc_pc_i,
  input  csr_pkg::exc_cause_t  exc_cause_i,
  input  logic                 irq_i,        // level
  input  logic [4:0]           irq_id_i,
  input  csr_pkg::csr_data_t   irq_pc_i,
  input  logic                 mie_i,
  input  logic                 mret_i,
  output csr_pkg::trap_save_t  save_o,
  output logic                 restore_o,
  output logic                 trap_o,
  output logic                 in_handler_o
);

  import csr_pkg::*;

  trap_state_e state_q, state_n;
  logic        take_irq;

  // irq only when enabled and no exception this cycle
  assign take_irq = irq_i && mie_i && !exc_req_i;
  assign trap_o   = exc_req_i || take_irq;

  always_comb
  begin
    save_o.save  = trap_o;
    save_o.pc    = exc_req_i ? exc_pc_i : irq_pc_i;
    save_o.cause = exc_req_i ? exc_cause_i : {1'b1, irq_id_i};
  end

  assign restore_o    = mret_i && (state_q == TRAP_HANDLER);
  assign in_handler_o = (state_q == TRAP_HANDLER);

  //////////////////////////////
  // state machine
  //////////////////////////////

  always_comb
  begin
    state_n = state_q;
    if (trap_o)
      state_n = TRAP_HANDLER;  // nested trap stays here
    else if (restore_o)
      state_n = TRAP_RUN;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state_q <= TRAP_RUN;
    else
      state_q <= state_n;
  end

  a_mret_in_handler : assert property (@(posedge clk) disable iff (!rst_n)
    mret_i |-> state_q == TRAP_HANDLER);
  a_no_save_restore : assert property (@(posedge clk) disable iff (!rst_n)
    !(save_o.save && restore_o));
  a_exc_not_mret : assert property (@(posedge clk) disable iff (!rst_n)
    !(exc_req_i && mret_i));

endmodule

// ==== source/perf_counters.sv ====
// performance counter bank
// one 32 bit counter per event with PCER enable mask and PCMR
// global enable / saturate, increments registered one cycle
// ahead of the add, CSR writes win over the increment

`timescale 1ns/100ps

`include "csr_defines.svh"

module perf_counters (
  input  logic                  clk,
  input  logic                  rst_n,
  input  csr_pkg::csr_sel_t     sel_i,
  input  csr_pkg::csr_data_t    wdata_i,
  input  csr_pkg::perf_evt_t    perf_evt_i,
  input  logic [`N_EXT_CNT-1:0] ext_evt_i,
  output csr_pkg::csr_data_t    rdata_o
);

  import csr_pkg::*;

  localparam int n_cnt = `N_PERF_CNT;

  logic [n_cnt-1:0] cnt_in;          // raw event per counter
  logic [n_cnt-1:0] inc, inc_q;      // gated event, registered
  logic [n_cnt-1:0] pcer_q, pcer_n;  // per counter enable
  logic [1:0]       pcmr_q, pcmr_n;  // [1] saturate, [0] enable

  csr_data_t [n_cnt-1:0] cnt_q, cnt_n;

  //////////////////////////////
  // event mapping
  //////////////////////////////

  assign cnt_in[0]  = 1'b1;                      // cycles
  assign cnt_in[1]  = perf_evt_i.instr;
  assign cnt_in[2]  = perf_evt_i.compressed;
  assign cnt_in[3]  = perf_evt_i.ld_stall;
  assign cnt_in[4]  = perf_evt_i.jr_stall;
  assign cnt_in[5]  = perf_evt_i.imiss;
  assign cnt_in[6]  = perf_evt_i.load;
  assign cnt_in[7]  = perf_evt_i.store;
  assign cnt_in[8]  = perf_evt_i.jump;
  assign cnt_in[9]  = perf_evt_i.branch;
  assign cnt_in[10] = perf_evt_i.branch_taken;

  for (genvar g = 0; g < `N_EXT_CNT; g++)
  begin : g_ext_evt
    assign cnt_in[`N_INT_CNT + g] = ext_evt_i[g];  // external events last
  end

  assign inc = cnt_in & pcer_q & {n_cnt{pcmr_q[0]}};

  //////////////////////////////
  // counter and control update
  //////////////////////////////

  always_comb
  begin
    for (int i = 0; i < n_cnt; i++)
    begin
      cnt_n[i] = cnt_q[i];
      // add last cycle's event unless pinned at all ones
      if (inc_q[i] && ((cnt_q[i] != '1) || !pcmr_q[1]))
        cnt_n[i] = cnt_q[i] + 32'd1;
      if (sel_i.pccr_all || (sel_i.pccr && (sel_i.pccr_idx == 5'(i))))
        cnt_n[i] = wdata_i;  // write beats increment
    end
  end

  always_comb
  begin
    pcer_n = pcer_q;
    pcmr_n = pcmr_q;
    if (sel_i.pcer)
      pcer_n = wdata_i[n_cnt-1:0];
    if (sel_i.pcmr)
      pcmr_n = wdata_i[1:0];
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cnt_q  <= '0;
      inc_q  <= '0;
      pcer_q <= '0;
      pcmr_q <= `PCMR_RST;
    end
    else
    begin
      cnt_q  <= cnt_n;
      inc_q  <= inc;
      pcer_q <= pcer_n;
      pcmr_q <= pcmr_n;
    end
  end

  // read side, out of range index and 79F read zero
  always_comb
  begin
    rdata_o = '0;
    if (sel_i.pcer)
      rdata_o[n_cnt-1:0] = pcer_q;
    else if (sel_i.pcmr)
      rdata_o[1:0] = pcmr_q;
    else if (sel_i.pccr)
    begin
      for (int i = 0; i < n_cnt; i++)
      begin
        if (sel_i.pccr_idx == 5'(i))
          rdata_o = cnt_q[i];
      end
    end
  end

endmodule

// ==== source/machine_csrs.sv ====
// machine mode CSRs
// mstatus (MIE, MPIE), mepc and mcause with CSR writes,
// trap save and mret restore, plus the read-only id registers

`timescale 1ns/100ps

`include "csr_defines.svh"

module machine_csrs (
  input  logic                 clk,
  input  logic                 rst_n,
  input  csr_pkg::csr_sel_t    sel_i,
  input  csr_pkg::csr_data_t   wdata_i,
  input  logic [9:0]           hart_id_i,    // cluster id, core id
  input  csr_pkg::csr_addr_t   read_addr_i,
  input  csr_pkg::trap_save_t  save_i,
  input  logic                 restore_i,
  output csr_pkg::csr_data_t   rdata_o,
  output logic                 mie_o,
  output csr_pkg::csr_data_t   mepc_o
);

  import csr_pkg::*;

  logic       mie_q, mie_n;     // global irq enable
  logic       mpie_q, mpie_n;   // MIE before trap
  csr_data_t  mepc_q, mepc_n;
  exc_cause_t mcause_q, mcause_n;

  //////////////////////////////
  // next state
  //////////////////////////////

  always_comb
  begin
    mie_n    = mie_q;
    mpie_n   = mpie_q;
    mepc_n   = mepc_q;
    mcause_n = mcause_q;

    // software writes first, trap control overrides below
    if (sel_i.mstatus)
    begin
      mie_n  = wdata_i[3];
      mpie_n = wdata_i[7];
    end
    if (sel_i.mepc)
      mepc_n = wdata_i;
    if (sel_i.mcause)
      mcause_n = {wdata_i[31], wdata_i[4:0]};

    if (save_i.save)
    begin
      mepc_n   = save_i.pc;
      mcause_n = save_i.cause;
      mpie_n   = mie_q;     // stack the enable
      mie_n    = 1'b0;      // irqs off in handler
    end
    else if (restore_i)
    begin
      mie_n = mpie_q;       // mret pops it back
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      mie_q    <= 1'b0;
      mpie_q   <= 1'b0;
      mepc_q   <= '0;
      mcause_q <= '0;
    end
    else
    begin
      mie_q    <= mie_n;
      mpie_q   <= mpie_n;
      mepc_q   <= mepc_n;
      mcause_q <= mcause_n;
    end
  end

  //////////////////////////////
  // read mux
  //////////////////////////////

  always_comb
  begin
    case (read_addr_i)
      `CSR_MSTATUS: rdata_o = {24'b0, mpie_q, 3'b0, mie_q, 3'b0};
      `CSR_MEPC:    rdata_o = mepc_q;
      `CSR_MCAUSE:  rdata_o = {mcause_q[5], 26'b0, mcause_q[4:0]};
      `CSR_MHARTID: rdata_o = {22'b0, hart_id_i};
      `CSR_MISA:    rdata_o = '0;   // not reported
      `CSR_MIMPID:  rdata_o = '0;   // no impl id
      default:      rdata_o = '0;   // unknown reads as zero
    endcase
  end

  assign mie_o  = mie_q;
  assign mepc_o = mepc_q;

endmodule

// ==== source/csr_decode.sv ====
// CSR address decode
// turns the request into one-hot write strobes, forms the
// set/clear/write value against the current read data and
// picks the read data of the machine block or the counter bank

`timescale 1ns/100ps

`include "csr_defines.svh"

module csr_decode (
  input  logic               clk,
  input  logic               rst_n,
  input  csr_pkg::csr_req_t  csr_req_i,
  input  csr_pkg::csr_data_t mach_rdata_i,
  input  csr_pkg::csr_data_t perf_rdata_i,
  output csr_pkg::csr_sel_t  sel_o,
  output csr_pkg::csr_data_t wdata_o,
  output csr_pkg::csr_data_t csr_rdata_o
);

  import csr_pkg::*;

  localparam csr_addr_t pccr_base = `CSR_PCCR_BASE;

  logic access_op;  // access with a real op
  logic perf_hit;   // any counter bank select

  assign access_op = csr_req_i.access && (csr_req_i.op != CSR_OP_NONE);

  //////////////////////////////
  // address match
  //////////////////////////////

  always_comb
  begin
    sel_o = '0;
    if (access_op)
    begin
      case (csr_req_i.addr)
        `CSR_MSTATUS:  sel_o.mstatus  = 1'b1;
        `CSR_MEPC:     sel_o.mepc     = 1'b1;
        `CSR_MCAUSE:   sel_o.mcause   = 1'b1;
        `CSR_PCER:     sel_o.pcer     = 1'b1;
        `CSR_PCMR:     sel_o.pcmr     = 1'b1;
        `CSR_PCCR_ALL: sel_o.pccr_all = 1'b1;
        default:
        begin
          // 780..79E, 79F already caught above
          if (csr_req_i.addr[11:5] == pccr_base[11:5])
          begin
            sel_o.pccr     = 1'b1;
            sel_o.pccr_idx = csr_req_i.addr[4:0];
          end
        end
      endcase
    end
  end

  //////////////////////////////
  // read mux and op combine
  //////////////////////////////

  assign perf_hit = sel_o.pcer | sel_o.pcmr | sel_o.pccr | sel_o.pccr_all;

  always_comb
  begin
    if (!csr_req_i.access)
      csr_rdata_o = '0;            // idle port reads zero
    else if (perf_hit)
      csr_rdata_o = perf_rdata_i;  // counter bank over machine
    else
      csr_rdata_o = mach_rdata_i;
  end

  always_comb
  begin
    unique case (csr_req_i.op)
      CSR_OP_WRITE: wdata_o = csr_req_i.wdata;
      CSR_OP_SET:   wdata_o = csr_req_i.wdata | csr_rdata_o;
      CSR_OP_CLEAR: wdata_o = ~csr_req_i.wdata & csr_rdata_o;
      CSR_OP_NONE:  wdata_o = csr_req_i.wdata;  // no strobe anyway
    endcase
  end

  // only one register written per access
  a_sel_onehot : assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({sel_o.mstatus, sel_o.mepc, sel_o.mcause, sel_o.pcer,
              sel_o.pcmr, sel_o.pccr, sel_o.pccr_all}));

endmodule

// ==== source/csr_pkg.sv ====
// CSR unit types
// data widths, op and state encodings and the bundles
// passed between decode, the machine CSRs, the counters and trap control

package csr_pkg;

  typedef logic [11:0] csr_addr_t;   // CSR address
  typedef logic [31:0] csr_data_t;   // data, pc and counter values
  typedef logic [5:0]  exc_cause_t;  // [5] irq flag, [4:0] code

  // CSR access op, same coding as the core decoder
  typedef enum logic [1:0] {
    CSR_OP_NONE  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  // register-like CSR request port, 47 bits
  typedef struct packed {
    logic      access;
    csr_op_e   op;
    csr_addr_t addr;
    csr_data_t wdata;
  } csr_req_t;

  // write strobes from decode, 12 bits
  typedef struct packed {
    logic       mstatus;
    logic       mepc;
    logic       mcause;
    logic       pcer;
    logic       pcmr;
    logic       pccr;      // single counter at pccr_idx
    logic       pccr_all;  // all counters
    logic [4:0] pccr_idx;
  } csr_sel_t;

  // core event strobes, counter 1 upward in this order
  typedef struct packed {
    logic instr;
    logic compressed;
    logic ld_stall;
    logic jr_stall;
    logic imiss;
    logic load;
    logic store;
    logic jump;
    logic branch;
    logic branch_taken;
  } perf_evt_t;

  // trap entry save bundle, 39 bits
  typedef struct packed {
    logic       save;
    csr_data_t  pc;
    exc_cause_t cause;
  } trap_save_t;

  typedef enum logic {
    TRAP_RUN,
    TRAP_HANDLER
  } trap_state_e;

endpackage

// ==== source/csr_defines.svh ====
// CSR unit constants
// machine and performance counter CSR addresses
// counter bank sizing and reset values of the counter control registers

`ifndef CSR_DEFINES_SVH
`define CSR_DEFINES_SVH

// machine mode CSRs
`define CSR_MSTATUS   12'h300
`define CSR_MISA      12'h301
`define CSR_MEPC      12'h341
`define CSR_MCAUSE    12'h342
`define CSR_MIMPID    12'hF13
`define CSR_MHARTID   12'hF14

// performance counter CSRs
`define CSR_PCER      12'h7A0   // event enable
`define CSR_PCMR      12'h7A1   // mode: saturate and enable
`define CSR_PCCR_BASE 12'h780   // counters sit at 780..79E
`define CSR_PCCR_ALL  12'h79F   // write hits every counter

// counter bank size
`define N_INT_CNT     11        // cycle plus 10 core events
`define N_EXT_CNT     2
`define N_PERF_CNT    (`N_INT_CNT + `N_EXT_CNT)

// PCMR after reset, bit 1 saturate and bit 0 enable
`define PCMR_RST      2'b11

`endif
